// File: bench/idct_model.svh
`ifndef IDCT_MODEL_SVH
`define IDCT_MODEL_SVH

`default_nettype none

// 8-point inverse transform as T' then W', in plain matrix form
function automatic void idct_1d_ref(input longint x [8], output longint w [8]);
	// coefficient of x0..x7 in each of t0..t7
	int tm [8][8] = '{
		'{39, 0, 0, 0, 0, 0, 0, 0},
		'{0, 0, 0, 0, 39, 0, 0, 0},
		'{0, 0, 36, 0, 0, 0, -15, 0},
		'{0, 0, 15, 0, 0, 0, 36, 0},
		'{0, 35, 0, -14, 0, 8, 0, -6},
		'{0, -2, 0, 19, 0, 30, 0, -16},
		'{0, 16, 0, 30, 0, -19, 0, -2},
		'{0, 6, 0, 8, 0, 14, 0, 35}
	};
	// sign of t0..t7 in each of w0..w7
	int sg [8][8] = '{
		'{1, 1, 1, 1, 1, 1, 1, 1},
		'{1, -1, 1, -1, 1, -1, 1, -1},
		'{1, -1, -1, 1, 1, -1, -1, 1},
		'{1, 1, -1, -1, 1, 1, -1, -1},
		'{1, 1, -1, -1, -1, -1, 1, 1},
		'{1, -1, -1, 1, -1, 1, 1, -1},
		'{1, -1, 1, -1, -1, 1, -1, 1},
		'{1, 1, 1, 1, -1, -1, -1, -1}
	};
	longint t [8];
	for (int i = 0; i < 8; i++) begin
		t[i] = '0;
		for (int j = 0; j < 8; j++) begin
			t[i] += tm[i][j] * x[j];
		end
	end
	for (int k = 0; k < 8; k++) begin
		w[k] = '0;
		for (int i = 0; i < 8; i++) begin
			w[k] += sg[k][i] * t[i];
		end
	end
endfunction

// rows first, then columns with the final shift
// pixels come back in column-major order
function automatic void idct_2d_ref(input idct_pkg::sample_t blk [64],
		output idct_pkg::pix_t pix [64]);
	longint x [8];
	longint w [8];
	idct_pkg::row_t r [64];
	for (int row = 0; row < 8; row++) begin
		for (int c = 0; c < 8; c++) begin
			x[c] = longint'(blk[row*8 + c]);
		end
		idct_1d_ref(x, w);
		for (int k = 0; k < 8; k++) begin
			r[row*8 + k] = idct_pkg::row_t'(w[k]);
		end
	end
	for (int col = 0; col < 8; col++) begin
		for (int k = 0; k < 8; k++) begin
			x[k] = longint'(r[k*8 + col]);
		end
		idct_1d_ref(x, w);
		for (int k = 0; k < 8; k++) begin
			pix[col*8 + k] = idct_pkg::pix_t'(w[k] >>> idct_pkg::COL_SHIFT);
		end
	end
endfunction

`default_nettype wire

`endif

// File: bench/idct_tb.sv
`include "idct_model.svh"
`default_nettype none

module idct_tb;

	// 8 + 64 + 8 accepted inputs between a sample and its pixel
	localparam int LATENCY = 80;
	localparam int N_RAND = 10;
	localparam int EXP_DEPTH = 4096;
	// negedges allowed for the tail of a test to come out
	localparam int DRAIN_LIMIT = 200;

	logic clk;
	logic rst;
	idct_pkg::sample_t i_sample;
	logic i_valid;
	idct_pkg::pix_t o_pixel;
	logic o_valid;
	logic o_first;

	integer seed = 32'hf8b3_be21;
	int errors = 0;
	bit timed_out = 1'b0;

	// block 0 stays zero and is also the flush block
	// block 1 constant, the rest random
	idct_pkg::sample_t blocks [N_RAND + 2][64];

	// expected pixels, pushed by the stimulus, popped per o_valid
	idct_pkg::pix_t exp_mem [EXP_DEPTH];
	idct_pkg::pix_t exp_head;
	int wr_idx = 0;
	int rd_idx = 0;
	int first_cnt = 0;

	// accepted inputs, and the count as seen three registers later
	int acc_cnt = 0;
	int acc_late = 0;
	logic [2:0] acc_d = '0;

	assign exp_head = exp_mem[rd_idx[11:0]];

	idct_2d_top idct_2d_top_i (
		.clk     (clk),
		.rst     (rst),
		.i_sample(i_sample),
		.i_valid (i_valid),
		.o_pixel (o_pixel),
		.o_valid (o_valid),
		.o_first (o_first)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// row stage, buffer and column stage each add one register
	always @(posedge clk) begin
		if (i_valid) begin
			acc_cnt <= acc_cnt + 1;
		end
		if (acc_d[1]) begin
			acc_late <= acc_late + 1;
		end
		acc_d <= {acc_d[1:0], i_valid};
	end

	// outputs are read at negedge, halfway between updates
	always @(negedge clk) begin
		if (!rst && o_valid) begin
			rd_idx <= rd_idx + 1;
		end
		if (!rst && o_first) begin
			first_cnt <= first_cnt + 1;
		end
	end

	a_pixel: assert property (@(negedge clk) disable iff (rst)
		o_valid |-> o_pixel == exp_head)
		else begin
			errors++;
			$display("CHECK FAILED t=%0t o_pixel expected %0d got %0d",
				$time, $sampled(exp_head), $sampled(o_pixel));
		end

	// nothing out before the pipeline holds 80 samples
	a_quiet: assert property (@(negedge clk) disable iff (rst)
		(acc_late <= LATENCY) |-> (!o_valid && !o_first))
		else begin
			errors++;
			$display("output appeared before %0d samples were accepted", LATENCY);
		end

	a_paced: assert property (@(negedge clk) disable iff (rst)
		o_valid |-> acc_d[2])
		else begin
			errors++;
			$display("pixel came out without a matching accepted input");
		end

	a_no_drop: assert property (@(negedge clk) disable iff (rst)
		(acc_d[2] && acc_late > LATENCY) |-> o_valid)
		else begin
			errors++;
			$display("accepted input gave no pixel once the pipeline was full");
		end

	// block start on pixel 0 of every 64
	a_first_pos: assert property (@(negedge clk) disable iff (rst)
		o_valid |-> o_first == (rd_idx % 64 == 0))
		else begin
			errors++;
			$display("CHECK FAILED t=%0t o_first expected %0b got %0b",
				$time, $sampled(rd_idx) % 64 == 0, $sampled(o_first));
		end

	a_first_valid: assert property (@(negedge clk) disable iff (rst)
		o_first |-> o_valid)
		else begin
			errors++;
			$display("o_first pulsed without o_valid");
		end

	// expected pixels go in first, then the 64 samples
	task automatic send_block(input int b, input bit gaps);
		idct_pkg::pix_t pix [64];
		int gap;
		idct_2d_ref(blocks[b], pix);
		for (int i = 0; i < 64; i++) begin
			exp_mem[wr_idx[11:0]] = pix[i];
			wr_idx++;
		end
		for (int i = 0; i < 64; i++) begin
			if (gaps) begin
				gap = $unsigned($random(seed)) % 4;
				if (gap > 0) begin
					i_valid <= 1'b0;
					repeat (gap) @(posedge clk);
				end
			end
			i_sample <= blocks[b][i];
			i_valid <= 1'b1;
			@(posedge clk);
		end
	endtask

	task automatic wait_drain(input int target, output bit ok);
		int n;
		n = 0;
		while (rd_idx < target && n < DRAIN_LIMIT) begin
			@(negedge clk);
			n++;
		end
		ok = (rd_idx >= target);
		if (!ok) begin
			$display("timed out with %0d of %0d pixels out", rd_idx, target);
		end
	endtask

	// two zero blocks behind each test push its pixels out
	task automatic run_test(input string name, input int first, input int count,
			input bit gaps);
		int err0;
		int px0;
		bit ok;
		if (!timed_out) begin
			err0 = errors;
			px0 = rd_idx;
			for (int b = first; b < first + count; b++) begin
				send_block(b, gaps);
			end
			send_block(0, 1'b0);
			send_block(0, 1'b0);
			i_valid <= 1'b0;
			wait_drain(wr_idx - LATENCY, ok);
			if (!ok) begin
				timed_out = 1'b1;
			end
			$display("%s: %0d pixels checked, %0d errors", name, rd_idx - px0,
				errors - err0);
		end
	endtask

	initial begin
		int err0;
		for (int b = 0; b < N_RAND + 2; b++) begin
			for (int i = 0; i < 64; i++) begin
				if (b == 0) begin
					blocks[b][i] = '0;
				end else if (b == 1) begin
					blocks[b][i] = idct_pkg::sample_t'(100);
				end else begin
					blocks[b][i] = idct_pkg::sample_t'($random(seed));
				end
			end
		end

		i_sample <= '0;
		i_valid <= 1'b0;
		rst <= 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		// idle after reset, a_quiet watches the outputs
		err0 = errors;
		repeat (10) @(posedge clk);
		$display("reset idle: 10 idle cycles, %0d errors", errors - err0);

		run_test("zero block", 0, 1, 1'b0);
		run_test("constant block", 1, 1, 1'b0);
		run_test("random back to back", 2, N_RAND, 1'b0);
		run_test("random with gaps", 2, N_RAND, 1'b1);

		if (!timed_out) begin
			err0 = errors;
			a_first_count: assert (first_cnt == (rd_idx + 63) / 64)
				else begin
					errors++;
					$display("CHECK FAILED t=%0t first_cnt expected %0d got %0d",
						$time, (rd_idx + 63) / 64, first_cnt);
				end
			a_total: assert (rd_idx == acc_cnt - LATENCY)
				else begin
					errors++;
					$display("CHECK FAILED t=%0t rd_idx expected %0d got %0d",
						$time, acc_cnt - LATENCY, rd_idx);
				end
			$display("block start: %0d o_first pulses, %0d errors", first_cnt,
				errors - err0);
		end

		$display("tests: 6, pixels checked: %0d, errors: %0d", rd_idx, errors);
		if (errors == 0 && !timed_out) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+bench
design/idct_pkg.sv
design/idct_1d_kernel.sv
design/idct_1d_stage.sv
design/transpose_buffer.sv
design/idct_2d_top.sv
bench/idct_tb.sv

// File: design/idct_1d_kernel.sv
`default_nettype none

module idct_1d_kernel #(
	parameter type in_t = idct_pkg::sample_t,
	parameter type out_t = idct_pkg::row_t
) (
	input wire in_t i_x [idct_pkg::N],
	output idct_pkg::acc_t o_w [idct_pkg::N]
);

	// inputs in the sum width
	idct_pkg::acc_t x [idct_pkg::N];
	// T' * x
	idct_pkg::acc_t t [idct_pkg::N];

	// gain per output is at most 440, so 9 bits on top of the input
	if ($bits(in_t) + 9 > idct_pkg::ACC_W || $bits(out_t) > idct_pkg::ACC_W) begin : g_width_err
		$error("idct_1d_kernel: payload does not fit the kernel sum width");
	end

	// sign extend every input
	always_comb begin
		for (int i = 0; i < idct_pkg::N; i++) begin
			x[i] = idct_pkg::acc_t'(i_x[i]);
		end
	end

	// even part, only x0 x2 x4 x6
	assign t[0] = idct_pkg::C39 * x[0];
	assign t[1] = idct_pkg::C39 * x[4];
	assign t[2] = idct_pkg::C36 * x[2] - idct_pkg::C15 * x[6];
	assign t[3] = idct_pkg::C15 * x[2] + idct_pkg::C36 * x[6];

	// odd part, four taps each
	assign t[4] = idct_pkg::C35 * x[1] - idct_pkg::C14 * x[3]
		+ idct_pkg::C8 * x[5] - idct_pkg::C6 * x[7];
	assign t[5] = idct_pkg::C19 * x[3] - idct_pkg::C2 * x[1]
		+ idct_pkg::C30 * x[5] - idct_pkg::C16 * x[7];
	assign t[6] = idct_pkg::C16 * x[1] + idct_pkg::C30 * x[3]
		- idct_pkg::C19 * x[5] - idct_pkg::C2 * x[7];
	assign t[7] = idct_pkg::C6 * x[1] + idct_pkg::C8 * x[3]
		+ idct_pkg::C14 * x[5] + idct_pkg::C35 * x[7];

	// w_k = signed sum of t over row k of W'
	for (genvar k = 0; k < idct_pkg::N; k++) begin : g_row
		// t with the row's sign applied
		idct_pkg::acc_t p [idct_pkg::N];
		// first level of the add tree
		idct_pkg::acc_t s [idct_pkg::N/2];
		// second level
		idct_pkg::acc_t q [2];

		for (genvar i = 0; i < idct_pkg::N; i++) begin : g_term
			assign p[i] = idct_pkg::W_NEG[k][i] ? -t[i] : t[i];
		end

		// neighbours pair up first
		for (genvar i = 0; i < idct_pkg::N/2; i++) begin : g_pair
			assign s[i] = p[2*i] + p[2*i+1];
		end

		assign q[0] = s[0] + s[1];
		assign q[1] = s[2] + s[3];
		// root of the tree
		assign o_w[k] = q[0] + q[1];
	end

endmodule

`default_nettype wire

// File: design/idct_1d_stage.sv
`default_nettype none

module idct_1d_stage #(
	parameter type in_t = idct_pkg::sample_t,
	parameter type out_t = idct_pkg::row_t,
	parameter int SHIFT = 0
) (
	input wire clk,
	input wire rst,
	input wire in_t i_data,
	input wire i_valid,
	input wire i_first,
	output out_t o_data,
	output logic o_valid,
	output logic o_first
);

	// element index inside the current block, counts accepted inputs
	logic [2:0] idx;
	logic last;
	// set once a whole block has gone through the kernel
	logic primed;
	// start flag of the block being captured, and of the one being sent
	logic first_cap;
	logic res_first;
	// every kernel result survives the narrowing to out_t
	logic fits;
	in_t cap [idct_pkg::N];
	in_t kin [idct_pkg::N];
	idct_pkg::acc_t kw [idct_pkg::N];
	// results of the previous block, read out by idx
	out_t res [idct_pkg::N];

	assign last = (idx == 3'(idct_pkg::N - 1));

	// element arriving now goes straight into the kernel
	// so the block is complete on the eighth strobe
	always_comb begin
		for (int i = 0; i < idct_pkg::N; i++) begin
			kin[i] = (idx == 3'(i)) ? i_data : cap[i];
		end
	end

	idct_1d_kernel #(
		.in_t (in_t),
		.out_t(out_t)
	) kernel_i (
		.i_x(kin),
		.o_w(kw)
	);

	// shifted sum read back from out_t must match the full sum
	always_comb begin
		fits = 1'b1;
		for (int i = 0; i < idct_pkg::N; i++) begin
			if (idct_pkg::acc_t'(out_t'(kw[i] >>> SHIFT)) != (kw[i] >>> SHIFT)) begin
				fits = 1'b0;
			end
		end
	end

	// capture, result bank and serialiser
	always_ff @(posedge clk) begin
		if (i_valid) begin
			cap[idx] <= i_data;
			// old bank entry leaves as the new element enters
			o_data <= res[idx];
			if (last) begin
				for (int i = 0; i < idct_pkg::N; i++) begin
					res[i] <= out_t'(kw[i] >>> SHIFT);
				end
			end
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			idx <= '0;
			primed <= 1'b0;
			first_cap <= 1'b0;
			res_first <= 1'b0;
			o_valid <= 1'b0;
			o_first <= 1'b0;
		end else begin
			// nothing to send until the first block is done
			o_valid <= i_valid && primed;
			o_first <= i_valid && primed && res_first && (idx == 3'd0);
			if (i_valid) begin
				idx <= idx + 3'd1;
				if (idx == 3'd0) begin
					first_cap <= i_first;
				end
				// flag travels with its block into the result bank
				if (last) begin
					primed <= 1'b1;
					res_first <= first_cap;
				end
			end
		end
	end

	// a latched block never overflows the result width
	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		i_valid && last |-> fits);

endmodule

`default_nettype wire

// File: design/idct_2d_top.sv
`default_nettype none

module idct_2d_top (
	input wire clk,
	input wire rst,
	input wire idct_pkg::sample_t i_sample,
	input wire i_valid,
	output idct_pkg::pix_t o_pixel,
	output logic o_valid,
	output logic o_first
);

	// row stage to transpose buffer
	idct_pkg::row_t row_data;
	logic row_valid;
	logic row_first;

	// transpose buffer to column stage
	idct_pkg::row_t tr_data;
	logic tr_valid;
	logic tr_first;

	// every row stage block is one image row, so each is a row start
	idct_1d_stage #(
		.in_t (idct_pkg::sample_t),
		.out_t(idct_pkg::row_t),
		.SHIFT(0)
	) row_stage_i (
		.clk    (clk),
		.rst    (rst),
		.i_data (i_sample),
		.i_valid(i_valid),
		.i_first(1'b1),
		.o_data (row_data),
		.o_valid(row_valid),
		.o_first(row_first)
	);

	transpose_buffer #(
		.data_t(idct_pkg::row_t)
	) transpose_i (
		.clk    (clk),
		.rst    (rst),
		.i_data (row_data),
		.i_valid(row_valid),
		.i_first(row_first),
		.o_data (tr_data),
		.o_valid(tr_valid),
		.o_first(tr_first)
	);

	// column pass, o_first only on column 0 of each 8x8 block
	idct_1d_stage #(
		.in_t (idct_pkg::row_t),
		.out_t(idct_pkg::pix_t),
		.SHIFT(idct_pkg::COL_SHIFT)
	) col_stage_i (
		.clk    (clk),
		.rst    (rst),
		.i_data (tr_data),
		.i_valid(tr_valid),
		.i_first(tr_first),
		.o_data (o_pixel),
		.o_valid(o_valid),
		.o_first(o_first)
	);

endmodule

`default_nettype wire

// File: design/idct_pkg.sv
`default_nettype none

package idct_pkg;

	// points per 1d transform, samples per 8x8 block
	localparam int N = 8;
	localparam int BLOCK = N * N;

	// signed input samples
	localparam int SAMPLE_W = 12;
	typedef logic signed [SAMPLE_W-1:0] sample_t;

	// row pass results
	// worst case 2048 * 440 needs 21 bits
	localparam int ROW_W = 24;
	typedef logic signed [ROW_W-1:0] row_t;

	// kernel sums, wide enough for a row_t input times the gain
	localparam int ACC_W = 48;
	typedef logic signed [ACC_W-1:0] acc_t;

	// output pixels
	localparam int PIX_W = 24;
	typedef logic signed [PIX_W-1:0] pix_t;

	// scale down after the column pass
	localparam int COL_SHIFT = 12;

	// integer entries of T'
	localparam acc_t C39 = 39;
	localparam acc_t C36 = 36;
	localparam acc_t C35 = 35;
	localparam acc_t C30 = 30;
	localparam acc_t C19 = 19;
	localparam acc_t C16 = 16;
	localparam acc_t C15 = 15;
	localparam acc_t C14 = 14;
	localparam acc_t C8 = 8;
	localparam acc_t C6 = 6;
	localparam acc_t C2 = 2;

	// rows of W', bit i set means t_i is subtracted
	localparam logic [N-1:0] W_NEG [N] = '{
		8'b0000_0000, 8'b1010_1010, 8'b0110_0110, 8'b1100_1100,
		8'b0011_1100, 8'b1001_0110, 8'b0101_1010, 8'b1111_0000
	};

endpackage

`default_nettype wire

// File: design/transpose_buffer.sv
`default_nettype none

module transpose_buffer #(
	parameter type data_t = idct_pkg::row_t
) (
	input wire clk,
	input wire rst,
	input wire data_t i_data,
	input wire i_valid,
	input wire i_first,
	output data_t o_data,
	output logic o_valid,
	output logic o_first
);

	// row * 8 + column of the next write
	logic [5:0] pos;
	logic [5:0] wr_pos;
	// same place with row and column swapped
	logic [5:0] rd_pos;
	logic wr_bank;
	// one whole block is stored in the read bank
	logic full;
	data_t mem [2][idct_pkg::BLOCK];

	// a row start from upstream puts the column back to 0
	assign wr_pos = i_first ? {pos[5:3], 3'd0} : pos;
	assign rd_pos = {wr_pos[2:0], wr_pos[5:3]};

	always_ff @(posedge clk) begin
		if (i_valid) begin
			mem[wr_bank][wr_pos] <= i_data;
			// previous block, column-major
			o_data <= mem[~wr_bank][rd_pos];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pos <= '0;
			wr_bank <= 1'b0;
			full <= 1'b0;
			o_valid <= 1'b0;
			o_first <= 1'b0;
		end else begin
			o_valid <= i_valid && full;
			o_first <= i_valid && full && (wr_pos == 6'd0);
			if (i_valid) begin
				pos <= wr_pos + 6'd1;
				// last word of a block, banks swap
				if (wr_pos == 6'(idct_pkg::BLOCK - 1)) begin
					wr_bank <= ~wr_bank;
					full <= 1'b1;
				end
			end
		end
	end

	// rows from the row stage always start on column 0
	a_row_start: assert property (@(posedge clk) disable iff (rst)
		i_valid && i_first |-> pos[2:0] == 3'd0);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the idct testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module idct_tb -f compile.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vidct_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the testbench verdict lives in the log
if grep -qx "Simulation passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
